// File: compile.f
+incdir+.
ccReqPkg.sv
ccXlatePkg.sv
ccShimIfs.sv
ccArbiter.sv
ccTlbSimple.sv
ccMemory.sv
ccShimTop.sv
ccShim_chk.sv
ccShimTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the shim testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module ccShimTb \
    -Mdir obj_dir -o simShim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simShim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

// File: ccShimTb.sv
// Testbench for the two-client memory shim, every ack is checked against a reference model
// The word memory has no reset, so it is filled through the shim before data is compared
// Assumes the default sizes in the config header
`include "ccShim_cfg.svh"

module ccShimTb;

    localparam int ClkPeriod = 40;
    localparam int NumPairs  = 16;
    localparam int NumStream = 40;
    localparam int MemWords  = 1 << `CC_PADDR_W;
    // Requests of the whole run: empty table, fill, pairs, fault and alias cases, streams
    localparam int NumReq    = 2 + MemWords + 2 * NumPairs + 5 + 2 * NumStream;

    logic               clk = 1'b0;
    logic               arstN;
    logic               req [2];
    ccReqPkg::opE       op [2];
    ccReqPkg::vaddrT    vaddr [2];
    ccReqPkg::dataT     wdata [2];
    logic               ack [2];
    ccReqPkg::dataT     rdata [2];
    ccReqPkg::statusE   status [2];
    logic               tblWe;
    ccXlatePkg::vpnT    tblVpn;
    ccXlatePkg::pteT    tblPte;

    // Reference model, a page-table copy and the memory contents
    ccXlatePkg::pteT    refPt [`CC_PT_DEPTH];
    ccReqPkg::dataT     refMem [MemWords];
    logic [MemWords-1:0] refKnown = '0;

    logic [31:0] lfsr = 32'h2e50;
    logic        idleCheck;
    logic [1:0]  ackSeen = '0;
    int          ackCount = 0;
    int          lastAcked = 0;
    logic        pendingAtAck = 1'b0;
    int          mismatchCount = 0;
    int          otherErrors = 0;

    always #(ClkPeriod / 2) clk = ~clk;

    ccShimTop i_ccShimTop (
        .clk     (clk),
        .arstN   (arstN),
        .req0    (req[0]),
        .op0     (op[0]),
        .vaddr0  (vaddr[0]),
        .wdata0  (wdata[0]),
        .ack0    (ack[0]),
        .rdata0  (rdata[0]),
        .status0 (status[0]),
        .req1    (req[1]),
        .op1     (op[1]),
        .vaddr1  (vaddr[1]),
        .wdata1  (wdata[1]),
        .ack1    (ack[1]),
        .rdata1  (rdata[1]),
        .status1 (status[1]),
        .tblWe   (tblWe),
        .tblVpn  (tblVpn),
        .tblPte  (tblPte)
    );

    // ============================================================
    // Random source and reference model
    // ============================================================

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step for each bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            lfsr = lfsrStep(lfsr);
        end
        return val;
    endfunction

    // Fill word, every bit of the physical address changes it
    function automatic ccReqPkg::dataT fillWord(input ccReqPkg::paddrT pa);
        return (32'(pa) * 32'h9e3779b1) ^ 32'h5a5a0000;
    endfunction

    // Physical word behind a virtual address, page offset passes through
    function automatic ccReqPkg::paddrT translate(input ccReqPkg::vaddrT va);
        ccXlatePkg::pteT pte;
        pte = refPt[va[`CC_VADDR_W-1:`CC_PAGE_OFS_W]];
        return {pte.ppn, va[`CC_PAGE_OFS_W-1:0]};
    endfunction

    // Expected status and data, a write returns the word it replaces
    // known is low while the memory word has never been written
    function automatic void expectXlate(input ccReqPkg::vaddrT va,
                                        output ccReqPkg::statusE st,
                                        output ccReqPkg::dataT d,
                                        output logic known);
        ccReqPkg::paddrT pa;
        pa = translate(va);
        if (!refPt[va[`CC_VADDR_W-1:`CC_PAGE_OFS_W]].valid) begin
            st = ccReqPkg::stFault;
            d = '0;
            known = 1'b1;
        end else begin
            st = ccReqPkg::stOk;
            d = refMem[pa];
            known = refKnown[pa];
        end
    endfunction

    task automatic checkStatus(input string sig, input ccReqPkg::statusE got,
                               input ccReqPkg::statusE exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s got %h expected %h", sig, got, exp);
        end
    endtask

    task automatic checkData(input string sig, input ccReqPkg::dataT got,
                             input ccReqPkg::dataT exp);
        if (got !== exp) begin
            mismatchCount++;
            $display("MISMATCH %s got %h expected %h", sig, got, exp);
        end
    endtask

    // ============================================================
    // Compare process, one check per rising ack
    // ============================================================
    always @(posedge clk) begin : compareAcks
        ccReqPkg::statusE expSt;
        ccReqPkg::dataT expData;
        ccReqPkg::paddrT pa;
        logic known;
        if (idleCheck && (ack[0] !== 1'b0 || ack[1] !== 1'b0)) begin
            otherErrors++;
            $display("ERROR an ack was not low while no request was pending");
        end
        for (int n = 0; n < 2; n++) begin
            if (ack[n] && !ackSeen[n]) begin
                expectXlate(vaddr[n], expSt, expData, known);
                checkStatus($sformatf("status%0d", n), status[n], expSt);
                if (known) begin
                    checkData($sformatf("rdata%0d", n), rdata[n], expData);
                end
                // Grant order follows ack order, so the model advances here
                if (expSt == ccReqPkg::stOk && op[n] == ccReqPkg::opWrite) begin
                    pa = translate(vaddr[n]);
                    refMem[pa] = wdata[n];
                    refKnown[pa] = 1'b1;
                end
                // Other client waited through the previous ack and was passed over
                if (ackCount != 0 && lastAcked == n && pendingAtAck && req[1 - n]) begin
                    otherErrors++;
                    $display("ERROR client %0d served twice while client %0d waited", n, 1 - n);
                end
                pendingAtAck = req[1 - n];
                lastAcked = n;
                ackCount++;
            end
            ackSeen[n] = ack[n];
        end
    end

    // ============================================================
    // Drivers
    // ============================================================

    // Four-phase handshake for one request of client n, called on a clock edge
    // Req rises on that same edge, so a client that was just served
    // competes with a waiting client in the next arbitration round
    task automatic runRequest(input int n, input ccReqPkg::opE o, input ccReqPkg::vaddrT va,
                              input ccReqPkg::dataT wd);
        req[n]   <= 1'b1;
        op[n]    <= o;
        vaddr[n] <= va;
        wdata[n] <= wd;
        do begin
            @(posedge clk);
        end while (!ack[n]);
        req[n] <= 1'b0;
        do begin
            @(posedge clk);
        end while (ack[n]);
    endtask

    // Table writes only happen with no request in flight
    task automatic loadPte(input ccXlatePkg::vpnT v, input logic valid,
                           input ccXlatePkg::ppnT p);
        @(posedge clk);
        tblWe  <= 1'b1;
        tblVpn <= v;
        tblPte <= {valid, p};
        refPt[v] = {valid, p};
        @(posedge clk);
        tblWe <= 1'b0;
    endtask

    initial begin : watchdog
        #(NumReq * 20 * ClkPeriod);
        $display("ERROR watchdog expired before all requests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : mainSeq
        logic [31:0]      r;
        ccReqPkg::vaddrT  va;
        ccReqPkg::dataT   wd;
        ccReqPkg::opE     sOp [2][NumStream];
        ccReqPkg::vaddrT  sVa [2][NumStream];
        ccReqPkg::dataT   sWd [2][NumStream];
        arstN     <= 1'b0;
        tblWe     <= 1'b0;
        tblVpn    <= '0;
        tblPte    <= '0;
        idleCheck <= 1'b1;
        for (int n = 0; n < 2; n++) begin
            req[n]   <= 1'b0;
            op[n]    <= ccReqPkg::opRead;
            vaddr[n] <= '0;
            wdata[n] <= '0;
        end
        for (int v = 0; v < `CC_PT_DEPTH; v++) begin
            refPt[v] = '0;
        end
        repeat (16) @(posedge clk);
        arstN <= 1'b1;

        // Quiet after reset, then every page faults with an empty table
        repeat (8) @(posedge clk);
        idleCheck <= 1'b0;
        runRequest(0, ccReqPkg::opRead, 10'h000, '0);
        runRequest(0, ccReqPkg::opWrite, 10'h3c5, 32'h12345678);

        // Each virtual page maps onto physical page vpn mod 8
        for (int v = 0; v < `CC_PT_DEPTH; v++) begin
            loadPte(ccXlatePkg::vpnT'(v), 1'b1, ccXlatePkg::ppnT'(v));
        end
        for (int a = 0; a < MemWords; a++) begin
            runRequest(0, ccReqPkg::opWrite, ccReqPkg::vaddrT'(a),
                       fillWord(ccReqPkg::paddrT'(a)));
        end

        // Random write then read back of the same address
        for (int i = 0; i < NumPairs; i++) begin
            r = randBits(10);
            va = r[`CC_VADDR_W-1:0];
            wd = randBits(32);
            runRequest(0, ccReqPkg::opWrite, va, wd);
            runRequest(0, ccReqPkg::opRead, va, '0);
        end

        // Faulting write leaves the word seen through alias page 13 unchanged
        loadPte(4'd5, 1'b0, 3'd0);
        runRequest(0, ccReqPkg::opWrite, {4'd5, 6'h11}, 32'hdead0011);
        runRequest(0, ccReqPkg::opRead, {4'd13, 6'h11}, '0);

        // Pages 2 and 10 share a physical page until 10 is remapped
        runRequest(0, ccReqPkg::opWrite, {4'd2, 6'h07}, 32'h0a11a502);
        runRequest(0, ccReqPkg::opRead, {4'd10, 6'h07}, '0);
        loadPte(4'd10, 1'b1, 3'd6);
        runRequest(0, ccReqPkg::opRead, {4'd10, 6'h07}, '0);

        // Both clients at once, the offset bit 5 keeps their words apart
        for (int n = 0; n < 2; n++) begin
            for (int i = 0; i < NumStream; i++) begin
                r = randBits(1);
                sOp[n][i] = ccReqPkg::opE'(r[0]);
                r = randBits(9);
                sVa[n][i] = {r[8:5], n[0], r[4:0]};
                sWd[n][i] = randBits(32);
            end
        end
        fork
            for (int i = 0; i < NumStream; i++) begin
                runRequest(0, sOp[0][i], sVa[0][i], sWd[0][i]);
            end
            for (int i = 0; i < NumStream; i++) begin
                runRequest(1, sOp[1][i], sVa[1][i], sWd[1][i]);
            end
        join

        repeat (4) @(posedge clk);
        if (ackCount != NumReq) begin
            $display("ERROR expected %0d acks but saw %0d", NumReq, ackCount);
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d acks checked",
                 mismatchCount, otherErrors, ackCount);
        if (mismatchCount == 0 && otherErrors == 0 && ackCount == NumReq) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: ccShim_chk.sv
// Handshake assertions bound into every ccArbiter instance
// Checks are disabled while arstN is low

module ccShimChk (
    input logic clk,
    input logic arstN,
    input logic busy,
    input logic downAck,
    input logic req0,
    input logic ack0,
    input logic req1,
    input logic ack1
);

    // The shim only answers while a client owns the port
    downAckNeedsGrant: assert property (@(posedge clk) disable iff (!arstN)
        downAck |-> busy)
        else $error("downstream ack high while no grant is held");

    // Ack holds until the client lets go of req
    ack0Held: assert property (@(posedge clk) disable iff (!arstN)
        (ack0 && req0) |=> ack0)
        else $error("client 0 ack fell before its req");

    ack1Held: assert property (@(posedge clk) disable iff (!arstN)
        (ack1 && req1) |=> ack1)
        else $error("client 1 ack fell before its req");

    // No response without an open request
    ack0NeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(ack0) |-> req0)
        else $error("client 0 ack rose while its req was low");

    ack1NeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(ack1) |-> req1)
        else $error("client 1 ack rose while its req was low");

endmodule

bind ccArbiter ccShimChk i_ccShimChk (
    .clk     (clk),
    .arstN   (arstN),
    .busy    (busy),
    .downAck (down.ack),
    .req0    (cli0.req),
    .ack0    (cli0.ack),
    .req1    (cli1.req),
    .ack1    (cli1.ack)
);

// File: ccShimTop.sv
// Two-client memory shim with page translation in front of a word memory
// Page-table writes are only legal while no request is in flight

module ccShimTop (
    input  logic               clk,
    input  logic               arstN,
    // Client 0
    input  logic               req0,
    input  ccReqPkg::opE       op0,
    input  ccReqPkg::vaddrT    vaddr0,
    input  ccReqPkg::dataT     wdata0,
    output logic               ack0,
    output ccReqPkg::dataT     rdata0,
    output ccReqPkg::statusE   status0,
    // Client 1
    input  logic               req1,
    input  ccReqPkg::opE       op1,
    input  ccReqPkg::vaddrT    vaddr1,
    input  ccReqPkg::dataT     wdata1,
    output logic               ack1,
    output ccReqPkg::dataT     rdata1,
    output ccReqPkg::statusE   status1,
    // Page-table load port
    input  logic               tblWe,
    input  ccXlatePkg::vpnT    tblVpn,
    input  ccXlatePkg::pteT    tblPte
);

    // Client paths, arbitrated path toward the shim, and the memory port
    memReqIf  c0If ();
    memReqIf  c1If ();
    memReqIf  dnIf ();
    memPortIf memIf ();

    // ============================================================
    // Plain client ports onto the request bundles
    // ============================================================
    assign c0If.req   = req0;
    assign c0If.op    = op0;
    assign c0If.vaddr = vaddr0;
    assign c0If.wdata = wdata0;
    assign ack0       = c0If.ack;
    assign rdata0     = c0If.rdata;
    assign status0    = c0If.status;

    assign c1If.req   = req1;
    assign c1If.op    = op1;
    assign c1If.vaddr = vaddr1;
    assign c1If.wdata = wdata1;
    assign ack1       = c1If.ack;
    assign rdata1     = c1If.rdata;
    assign status1    = c1If.status;

    // ============================================================
    // Block instances
    // ============================================================
    ccArbiter i_ccArbiter (
        .clk   (clk),
        .arstN (arstN),
        .cli0  (c0If.shim),
        .cli1  (c1If.shim),
        .down  (dnIf.client)
    );

    ccTlbSimple i_ccTlbSimple (
        .clk    (clk),
        .arstN  (arstN),
        .up     (dnIf.shim),
        .mem    (memIf.master),
        .tblWe  (tblWe),
        .tblVpn (tblVpn),
        .tblPte (tblPte)
    );

    ccMemory i_ccMemory (
        .clk  (clk),
        .port (memIf.slave)
    );

endmodule

// File: ccMemory.sv
// Single-port word memory with a registered read, contents undefined at start
// A write also returns the old word one cycle later
`include "ccShim_cfg.svh"

module ccMemory (
    input  logic     clk,
    memPortIf.slave  port
);

    // 512 words with the default physical address width
    ccReqPkg::dataT memArray [1 << `CC_PADDR_W];

    // Read register, only loaded on an enabled cycle
    ccReqPkg::dataT rdataQ;

    always_ff @(posedge clk) begin
        if (port.en) begin
            if (port.we) begin
                memArray[port.addr] <= port.wdata;
            end
            // Read before write on the same address
            rdataQ <= memArray[port.addr];
        end
    end

    assign port.rdata = rdataQ;

endmodule

// File: ccTlbSimple.sv
// Virtual to physical translation through a 16-entry page table
// The table is loaded from outside and must not change while a request is open
`include "ccShim_cfg.svh"

module ccTlbSimple (
    input  logic               clk,
    input  logic               arstN,
    memReqIf.shim              up,
    memPortIf.master           mem,
    input  logic               tblWe,
    input  ccXlatePkg::vpnT    tblVpn,
    input  ccXlatePkg::pteT    tblPte
);

    // Whole translation map, one entry per virtual page
    ccXlatePkg::pteT pageTable [`CC_PT_DEPTH];

    // Sequencer state
    ccXlatePkg::shimStateE state;

    // Entry read for the request in progress
    ccXlatePkg::pteT pteQ;

    // Split of the incoming virtual address
    ccXlatePkg::vpnT reqVpn;
    logic [`CC_PAGE_OFS_W-1:0] reqOfs;

    assign reqVpn = up.vaddr[`CC_VADDR_W-1:`CC_PAGE_OFS_W];
    assign reqOfs = up.vaddr[`CC_PAGE_OFS_W-1:0];

    // ============================================================
    // Page table
    // ============================================================

    // Every page starts unmapped so all requests fault until loaded
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CC_PT_DEPTH; i++) begin
                pageTable[i] <= '0;
            end
        end else if (tblWe) begin
            pageTable[tblVpn] <= tblPte;
        end
    end

    // Table lookup takes the first cycle of a request
    // The entry stays put until the next request starts
    always_ff @(posedge clk) begin
        if (state == ccXlatePkg::tsIdle && up.req) begin
            pteQ <= pageTable[reqVpn];
        end
    end

    // ============================================================
    // Request sequencer
    // ============================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= ccXlatePkg::tsIdle;
        end else begin
            case (state)
                ccXlatePkg::tsIdle: begin
                    if (up.req) begin
                        state <= ccXlatePkg::tsXlate;
                    end
                end
                // Invalid pages skip the memory and report a fault
                ccXlatePkg::tsXlate: begin
                    state <= pteQ.valid ? ccXlatePkg::tsAccess : ccXlatePkg::tsAck;
                end
                ccXlatePkg::tsAccess: begin
                    state <= ccXlatePkg::tsAck;
                end
                // Hold the response until the requester lets go
                ccXlatePkg::tsAck: begin
                    if (!up.req) begin
                        state <= ccXlatePkg::tsIdle;
                    end
                end
                default: begin
                    state <= ccXlatePkg::tsIdle;
                end
            endcase
        end
    end

    // ============================================================
    // Memory access and response
    // ============================================================

    // Memory is only enabled for a valid page
    assign mem.en    = (state == ccXlatePkg::tsAccess);
    assign mem.we    = mem.en && (up.op == ccReqPkg::opWrite);
    assign mem.addr  = {pteQ.ppn, reqOfs};
    assign mem.wdata = up.wdata;

    // Memory output holds its value while en is low, so it stays valid in tsAck
    // A write returns the word it replaced
    assign up.ack    = (state == ccXlatePkg::tsAck);
    assign up.status = (up.ack && !pteQ.valid) ? ccReqPkg::stFault : ccReqPkg::stOk;
    assign up.rdata  = (up.ack && pteQ.valid) ? mem.rdata : '0;

endmodule

// File: ccArbiter.sv
// Round-robin arbiter for two four-phase clients onto one shim port
// Serves one request at a time; client 0 wins the first tie after reset

module ccArbiter (
    input  logic     clk,
    input  logic     arstN,
    memReqIf.shim    cli0,
    memReqIf.shim    cli1,
    memReqIf.client  down
);

    // Set while a client owns the downstream port
    logic busy;
    // Index of the client that owns the port
    logic grant;
    // Client served by the most recent grant
    logic lastServed;
    // Registered request toward the shim
    logic downReq;
    // Choice among the pending clients while idle
    logic winner;
    // Current req of the granted client
    logic grantReq;

    // On a tie the client not served last wins,
    // otherwise the single requester is taken
    assign winner = (cli0.req && cli1.req) ? ~lastServed : cli1.req;

    assign grantReq = grant ? cli1.req : cli0.req;

    // ============================================================
    // Grant tracking
    // ============================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy       <= 1'b0;
            grant      <= 1'b0;
            lastServed <= 1'b1;
            downReq    <= 1'b0;
        end else if (!busy) begin
            // A req seen while idle is granted at this edge
            if (cli0.req || cli1.req) begin
                busy    <= 1'b1;
                grant   <= winner;
                downReq <= 1'b1;
            end
        end else begin
            // Follow the client req down but never raise it again,
            // a new req waits for the next arbitration round
            downReq <= downReq && grantReq;
            // The shim dropped ack after req fell, so the round is over
            if (!downReq && !down.ack) begin
                busy       <= 1'b0;
                lastServed <= grant;
            end
        end
    end

    // ============================================================
    // Request and response routing
    // ============================================================

    // Fields of the granted client pass straight through
    assign down.req   = downReq;
    assign down.op    = grant ? cli1.op    : cli0.op;
    assign down.vaddr = grant ? cli1.vaddr : cli0.vaddr;
    assign down.wdata = grant ? cli1.wdata : cli0.wdata;

    // Only the granted client sees the response, the other reads idle values
    assign cli0.ack    = busy && !grant && down.ack;
    assign cli0.rdata  = (busy && !grant) ? down.rdata : '0;
    assign cli0.status = (busy && !grant) ? down.status : ccReqPkg::stOk;

    assign cli1.ack    = busy && grant && down.ack;
    assign cli1.rdata  = (busy && grant) ? down.rdata : '0;
    assign cli1.status = (busy && grant) ? down.status : ccReqPkg::stOk;

endmodule

// File: ccShimIfs.sv
// Request and memory port bundles used inside the shim
// memReqIf follows a four-phase req/ack handshake

// ============================================================
// One request path between a client and the shim side
// ============================================================
interface memReqIf;

    // Request fields, held stable by the client until ack rises
    logic              req;
    ccReqPkg::opE      op;
    ccReqPkg::vaddrT   vaddr;
    ccReqPkg::dataT    wdata;

    // Response fields, valid and held while ack is high
    logic              ack;
    ccReqPkg::dataT    rdata;
    ccReqPkg::statusE  status;

    // Requester side
    modport client (output req, op, vaddr, wdata, input ack, rdata, status);

    // Responder side
    modport shim (input req, op, vaddr, wdata, output ack, rdata, status);

endinterface

// ============================================================
// Word memory port, rdata lags en by one cycle
// ============================================================
interface memPortIf;

    logic             en;
    logic             we;
    ccReqPkg::paddrT  addr;
    ccReqPkg::dataT   wdata;
    ccReqPkg::dataT   rdata;

    modport master (output en, we, addr, wdata, input rdata);
    modport slave (input en, we, addr, wdata, output rdata);

endinterface

// File: ccXlatePkg.sv
// Translation types for the page table and the shim sequencer
// Page number widths follow from the address and offset widths
`include "ccShim_cfg.svh"

package ccXlatePkg;

    // Upper bits of the virtual address, 4 bits with the default config
    typedef logic [`CC_VADDR_W-`CC_PAGE_OFS_W-1:0] vpnT;

    // Upper bits of the physical address, 3 bits with the default config
    typedef logic [`CC_PADDR_W-`CC_PAGE_OFS_W-1:0] ppnT;

    // One page-table entry, an all zero entry is invalid
    typedef struct packed {
        logic valid;
        ppnT  ppn;
    } pteT;

    // Sequencer states of the translation shim
    typedef enum logic [1:0] {
        tsIdle,
        tsXlate,
        tsAccess,
        tsAck
    } shimStateE;

endpackage

// File: ccReqPkg.sv
// Request-side types seen by the clients and the shim
// Word size and address widths come from the shared config header
`include "ccShim_cfg.svh"

package ccReqPkg;

    // Access type of one request
    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } opE;

    // Completion status returned with ack
    // A fault means the page had no valid mapping
    typedef enum logic {
        stOk    = 1'b0,
        stFault = 1'b1
    } statusE;

    // One memory word
    typedef logic [`CC_DATA_W-1:0] dataT;

    // Address as issued by a client
    typedef logic [`CC_VADDR_W-1:0] vaddrT;

    // Address after translation, indexes the word memory
    typedef logic [`CC_PADDR_W-1:0] paddrT;

endpackage

// File: ccShim_cfg.svh
// Global sizes of the memory shim, shared by both packages and the RTL
// CC_PT_DEPTH must equal 2**(CC_VADDR_W - CC_PAGE_OFS_W)
// CC_PADDR_W must be larger than CC_PAGE_OFS_W
`ifndef CC_SHIM_CFG_SVH
`define CC_SHIM_CFG_SVH

// Width of one memory word in bits
`define CC_DATA_W 32

// Client side address width, 4 page bits over the offset
`define CC_VADDR_W 10

// Memory side address width, 512 words in total
`define CC_PADDR_W 9

// Offset inside a page, passed through untranslated
`define CC_PAGE_OFS_W 6

// One page-table entry per virtual page
`define CC_PT_DEPTH 16

`endif
